/* src.f */
+incdir+logic
logic/frontend_pkg.sv
logic/sfifo2.sv
logic/mrq.sv
logic/imem.sv
logic/fetch_requester.sv
logic/predecode.sv
logic/fetch_frontend.sv
tests/fetch_frontend_tb.sv

/* tests/fetch_frontend_tb.sv */
// Directed testbench for the fetch frontend that is compiled from src.f with fetch_frontend_tb as top
`timescale 1ns/10ps
`include "frontend_macros.svh"

module fetch_frontend_tb;
    localparam int PCW   = `PC_BITS;
    localparam int LINES = `IMEM_DEPTH_LINES;
    // Number of PC units in one 32-bit word, which is two when PCs count halfwords
    localparam int WORD_STEP = (`ENABLE_C_EXTENSION == 1) ? 2 : 1;

    logic                        core_clock = 1'b0;
    logic                        reset;
    logic                        redirect;
    logic [PCW-1:0]              redirect_vpc;
    logic                        imem_we;
    logic [`IMEM_ADDR_BITS-1:0]  imem_addr;
    logic [63:0]                 imem_wdata;
    logic                        dec_vld;
    frontend_pkg::predecoded_t   dec_instr;
    logic                        dec_busy;

    // Reference copy of the program and the words still expected at the output
    logic [63:0]                 mem_model [LINES];
    frontend_pkg::predecoded_t   exp_q [$];
    frontend_pkg::predecoded_t   head;
    frontend_pkg::predecoded_t   held;
    int                          accepted = 0;
    int                          faults_seen = 0;
    logic [PCW-1:0]              last_pc;

    fetch_frontend uut (
        .core_clock_i   (core_clock),
        .reset_i        (reset),
        .redirect_i     (redirect),
        .redirect_vpc_i (redirect_vpc),
        .imem_we_i      (imem_we),
        .imem_addr_i    (imem_addr),
        .imem_wdata_i   (imem_wdata),
        .dec_vld_o      (dec_vld),
        .dec_instr_o    (dec_instr),
        .dec_busy_i     (dec_busy)
    );

    always #10 core_clock = ~core_clock;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] received);
        assert (received === expected) else begin
            report_failure($sformatf("[FAIL] time %0t: %s expected %h, received %h",
                                     $time, name, expected, received));
        end
    endtask

    // Instruction class from opcode bits 6:0
    function automatic frontend_pkg::instr_class_e expected_class(input logic [6:0] op);
        if (op == 7'b1100011) return frontend_pkg::CLS_BRANCH;
        if (op == 7'b1101111) return frontend_pkg::CLS_JAL;
        if (op == 7'b1100111) return frontend_pkg::CLS_JALR;
        if (op == 7'b0000011) return frontend_pkg::CLS_LOAD;
        if (op == 7'b0100011) return frontend_pkg::CLS_STORE;
        return frontend_pkg::CLS_OTHER;
    endfunction

    // Expected word at a PC from the program copy or as a fault past the end of memory
    function automatic frontend_pkg::predecoded_t expected_word(input logic [PCW-1:0] pc);
        frontend_pkg::predecoded_t e;
        int unsigned word;
        word = pc / WORD_STEP;
        e.vpc = pc;
        e.excp_vld = (word / 2) >= LINES;
        if (e.excp_vld) begin
            e.instruction = 32'd0;
            e.excp_code = frontend_pkg::EXC_INSTR_ACCESS_FAULT;
        end else begin
            e.instruction = mem_model[word / 2][32 * (word % 2) +: 32];
            e.excp_code = frontend_pkg::EXC_NONE;
        end
        e.iclass = expected_class(e.instruction[6:0]);
        return e;
    endfunction

    // Rebuilds the expected stream from a start PC through memory and into some faulted words
    function automatic void fill_expected(input logic [PCW-1:0] start_pc);
        exp_q.delete();
        for (int i = 0; i < 2 * LINES + 32; i++) begin
            exp_q.push_back(expected_word(start_pc + PCW'(i * WORD_STEP)));
        end
    endfunction

    // Every word taken while busy is low must be the head of the expected stream
    always @(negedge core_clock) begin
        if (reset) begin
            check_value("dec_vld_o in reset", 64'd0, 64'(dec_vld));
        end else if (dec_vld && !dec_busy) begin
            assert (exp_q.size() != 0) else begin
                report_failure("An instruction came out although none was expected");
            end
            head = exp_q.pop_front();
            check_value("dec_instr_o.vpc", 64'(head.vpc), 64'(dec_instr.vpc));
            check_value("dec_instr_o.instruction", 64'(head.instruction),
                        64'(dec_instr.instruction));
            check_value("dec_instr_o.iclass", 64'(head.iclass), 64'(dec_instr.iclass));
            check_value("dec_instr_o.excp_code", 64'(head.excp_code),
                        64'(dec_instr.excp_code));
            check_value("dec_instr_o.excp_vld", 64'(head.excp_vld), 64'(dec_instr.excp_vld));
            last_pc = dec_instr.vpc;
            accepted++;
            faults_seen += dec_instr.excp_vld;
        end
    end

    task automatic write_line(input int line, input logic [63:0] data);
        @(posedge core_clock);
        imem_we    <= 1'b1;
        imem_addr  <= line[`IMEM_ADDR_BITS-1:0];
        imem_wdata <= data;
        mem_model[line] = data;
    endtask

    // One line goes in per clock. Reset drops after 8 cycles and fetch trails behind the writes
    task automatic load_program();
        for (int i = 0; i < LINES; i++) begin
            write_line(i, mem_model[i]);
            if (i == 7) reset <= 1'b0;
        end
        @(posedge core_clock);
        imem_we <= 1'b0;
    endtask

    // Waits for count more accepted words while dec_busy_i is high in busy_pct percent of cycles
    task automatic wait_outputs(input int count, input int busy_pct);
        int target;
        int cycles;
        target = accepted + count;
        cycles = 0;
        while (accepted < target) begin
            @(posedge core_clock);
            dec_busy <= ($urandom % 100) < busy_pct;
            cycles++;
            assert (cycles <= 40 * count + 100) else begin
                report_failure("Timed out waiting for dec_vld_o");
            end
        end
    endtask

    task automatic redirect_to(input logic [PCW-1:0] pc);
        @(posedge core_clock);
        redirect     <= 1'b1;
        redirect_vpc <= pc;
        @(posedge core_clock);
        redirect <= 1'b0;
        fill_expected(pc);
    endtask

    task automatic check_redirect_target(input logic [PCW-1:0] pc);
        redirect_to(pc);
        wait_outputs(1, 0);
        check_value("first dec_instr_o.vpc after redirect", 64'(pc), 64'(last_pc));
        wait_outputs(7, 0);
    endtask

    task automatic check_end_of_memory();
        int faults_before;
        faults_before = faults_seen;
        redirect_to(PCW'((2 * LINES - 3) * WORD_STEP));
        wait_outputs(12, 0);
        assert (faults_seen > faults_before) else begin
            report_failure("No access fault came out after the last memory line");
        end
    endtask

    // Known opcodes go into three lines with the low word first
    task automatic check_classes();
        write_line(40, {25'($urandom), 7'b1101111, 25'($urandom), 7'b1100011});
        write_line(41, {25'($urandom), 7'b0000011, 25'($urandom), 7'b1100111});
        write_line(42, {25'($urandom), 7'b0010011, 25'($urandom), 7'b0100011});
        @(posedge core_clock);
        imem_we <= 1'b0;
        redirect_to(PCW'(80 * WORD_STEP));
        wait_outputs(6, 0);
    endtask

    // Holding the consumer fills the queue and the stream must then resume intact
    task automatic check_long_hold();
        int cycles;
        @(posedge core_clock);
        dec_busy <= 1'b1;
        redirect_to(PCW'(10 * WORD_STEP));
        cycles = 0;
        while (!uut.mrq_busy) begin
            @(posedge core_clock);
            cycles++;
            assert (cycles <= 200) else begin
                report_failure("The response queue never filled while held");
            end
        end
        @(negedge core_clock);
        held = dec_instr;
        repeat (10) @(posedge core_clock);
        @(negedge core_clock);
        check_value("dec_vld_o while busy", 64'd1, 64'(dec_vld));
        check_value("dec_instr_o.vpc while busy", 64'(held.vpc), 64'(dec_instr.vpc));
        check_value("dec_instr_o.instruction while busy", 64'(held.instruction),
                    64'(dec_instr.instruction));
        wait_outputs(40, 0);
    endtask

    initial begin
        void'($urandom(32'h2946));
        reset        = 1'b1;
        redirect     = 1'b0;
        redirect_vpc = '0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        dec_busy     = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            mem_model[i] = {$urandom, $urandom};
        end
        fill_expected(PCW'(`RESET_VPC));
        load_program();
        wait_outputs(24, 0);
        redirect_to(PCW'(0));
        wait_outputs(60, 50);
        wait_outputs(6, 0);
        check_redirect_target(PCW'(20 * WORD_STEP));
        check_redirect_target(PCW'(37 * WORD_STEP));
        check_end_of_memory();
        check_classes();
        check_long_hold();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* logic/fetch_frontend.sv */
// Frontend top level joining fetch requester, instruction memory, mrq and predecode
`timescale 1ns/10ps
`include "frontend_macros.svh"

module fetch_frontend (
    input  wire logic                         core_clock_i,
    input  wire logic                         reset_i,

    input  wire logic                         redirect_i,
    input  wire logic [`PC_BITS-1:0]          redirect_vpc_i,

    input  wire logic                         imem_we_i,
    input  wire logic [`IMEM_ADDR_BITS-1:0]   imem_addr_i,
    input  wire logic [63:0]                  imem_wdata_i,

    output wire logic                         dec_vld_o,
    output wire frontend_pkg::predecoded_t    dec_instr_o,
    input  wire logic                         dec_busy_i
);
    // Memory read path
    logic                         rd_en;
    logic [`IMEM_ADDR_BITS-1:0]   rd_addr;
    logic [63:0]                  rd_data;

    // Requester to queue
    logic                         mrq_vld;
    frontend_pkg::fetch_packet_t  mrq_packet;
    logic                         mrq_busy;

    // Queue to predecode
    logic                         nx_vld;
    frontend_pkg::fetch_packet_t  nx_packet;
    logic                         nx_busy;

    fetch_requester u_fetch_requester (
        .core_clock_i   (core_clock_i),
        .reset_i        (reset_i),
        .redirect_i     (redirect_i),
        .redirect_vpc_i (redirect_vpc_i),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .mrq_vld_o      (mrq_vld),
        .mrq_packet_o   (mrq_packet),
        .mrq_busy_i     (mrq_busy)
    );

    imem u_imem (
        .core_clock_i (core_clock_i),
        .we_i         (imem_we_i),
        .waddr_i      (imem_addr_i),
        .wdata_i      (imem_wdata_i),
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data)
    );

    // The redirect is the only flush source
    mrq u_mrq (
        .core_clock_i      (core_clock_i),
        .core_flush_i      (redirect_i),
        .reset_i           (reset_i),
        .mrq_vld_i         (mrq_vld),
        .mrq_packet_i      (mrq_packet),
        .mrq_busy_o        (mrq_busy),
        .nx_stage_vld_o    (nx_vld),
        .nx_stage_packet_o (nx_packet),
        .nx_stage_busy_i   (nx_busy)
    );

    predecode u_predecode (
        .core_clock_i (core_clock_i),
        .reset_i      (reset_i),
        .flush_i      (redirect_i),
        .in_vld_i     (nx_vld),
        .in_packet_i  (nx_packet),
        .in_busy_o    (nx_busy),
        .dec_vld_o    (dec_vld_o),
        .dec_instr_o  (dec_instr_o),
        .dec_busy_i   (dec_busy_i)
    );

endmodule

/* logic/predecode.sv */
// Predecode stage that splits each fetch packet into two classified 32-bit instructions
`timescale 1ns/10ps
`include "frontend_macros.svh"

module predecode #(
    localparam int PCW      = `PC_BITS,
    localparam int WORD_BIT = `LINE_SHIFT - 1
) (
    input  wire logic                         core_clock_i,
    input  wire logic                         reset_i,
    input  wire logic                         flush_i,

    input  wire logic                         in_vld_i,
    input  wire frontend_pkg::fetch_packet_t  in_packet_i,
    output wire logic                         in_busy_o,

    output wire logic                         dec_vld_o,
    output wire frontend_pkg::predecoded_t    dec_instr_o,
    input  wire logic                         dec_busy_i
);
    frontend_pkg::fetch_packet_t pkt_q;

    // Held flag, and which half goes out next
    logic           held_q;
    logic           sel_q;
    logic           advance;
    logic           take;
    logic [31:0]    word;
    logic [PCW-1:0] line_vpc;
    logic [PCW-1:0] word_vpc;

    // Class comes from the major opcode only
    function automatic frontend_pkg::instr_class_e classify(input logic [6:0] opcode);
        frontend_pkg::instr_class_e cls;
        case (opcode)
            frontend_pkg::OP_BRANCH: cls = frontend_pkg::CLS_BRANCH;
            frontend_pkg::OP_JAL:    cls = frontend_pkg::CLS_JAL;
            frontend_pkg::OP_JALR:   cls = frontend_pkg::CLS_JALR;
            frontend_pkg::OP_LOAD:   cls = frontend_pkg::CLS_LOAD;
            frontend_pkg::OP_STORE:  cls = frontend_pkg::CLS_STORE;
            default:                 cls = frontend_pkg::CLS_OTHER;
        endcase
        return cls;
    endfunction

    // The upper half is always the last word of a packet
    assign advance   = held_q && !dec_busy_i;
    assign in_busy_o = held_q && (dec_busy_i || !sel_q);
    assign take      = in_vld_i && !in_busy_o;

    always_ff @(posedge core_clock_i) begin
        if (reset_i || flush_i) begin
            held_q <= 1'b0;
            sel_q  <= 1'b0;
        end else if (take) begin
            // A redirect into the upper word skips the low word of its first line
            held_q <= 1'b1;
            sel_q  <= in_packet_i.vpc[WORD_BIT];
        end else if (advance) begin
            held_q <= !sel_q;
            sel_q  <= 1'b1;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (take) begin
            pkt_q <= in_packet_i;
        end
    end

    // Rebuild the word PC from the line base and the half select
    assign line_vpc = {pkt_q.vpc[PCW-1:`LINE_SHIFT], {`LINE_SHIFT{1'b0}}};
    assign word_vpc = line_vpc | (PCW'(sel_q) << WORD_BIT);
    assign word     = sel_q ? pkt_q.instruction[63:32] : pkt_q.instruction[31:0];

    assign dec_vld_o = held_q;

    // Both halves carry the line's exception
    assign dec_instr_o.instruction = word;
    assign dec_instr_o.vpc         = word_vpc;
    assign dec_instr_o.iclass      = classify(word[6:0]);
    assign dec_instr_o.excp_code   = pkt_q.excp_code;
    assign dec_instr_o.excp_vld    = pkt_q.excp_vld;

endmodule

/* logic/fetch_requester.sv */
// PC sequencer that reads instruction memory and pushes tagged fetch packets into the mrq
`timescale 1ns/10ps
`include "frontend_macros.svh"

module fetch_requester #(
    localparam int PCW       = `PC_BITS,
    localparam int LINE_BITS = `PC_BITS - `LINE_SHIFT,
    localparam int ADDR_BITS = `IMEM_ADDR_BITS
) (
    input  wire logic                         core_clock_i,
    input  wire logic                         reset_i,

    input  wire logic                         redirect_i,
    input  wire logic [PCW-1:0]               redirect_vpc_i,

    output wire logic                         rd_en_o,
    output wire logic [ADDR_BITS-1:0]         rd_addr_o,
    input  wire logic [63:0]                  rd_data_i,

    output wire logic                         mrq_vld_o,
    output wire frontend_pkg::fetch_packet_t  mrq_packet_o,
    input  wire logic                         mrq_busy_i
);
    frontend_pkg::fetch_state_e state_q;

    // Next PC to fetch, and the PC and fault flag of the read in flight
    logic [PCW-1:0]       pc_q;
    logic [PCW-1:0]       req_pc_q;
    logic                 req_fault_q;
    logic [LINE_BITS-1:0] pc_line;
    logic                 pc_fault;
    logic [PCW-1:0]       redirect_pc;

    assign pc_line  = pc_q[PCW-1:`LINE_SHIFT];
    assign pc_fault = pc_line >= LINE_BITS'(`IMEM_DEPTH_LINES);

    // Targets are word aligned, the halfword bit is cleared when C is on
    assign redirect_pc = redirect_vpc_i & ~PCW'(`ENABLE_C_EXTENSION);

    // IDLE waits for room in the mrq, ISSUE drives the memory, RESP hands the data on
    always_ff @(posedge core_clock_i) begin
        if (reset_i) begin
            state_q <= frontend_pkg::FR_IDLE;
            pc_q    <= PCW'(`RESET_VPC);
        end else if (redirect_i) begin
            // Anything in flight is simply abandoned
            state_q <= frontend_pkg::FR_IDLE;
            pc_q    <= redirect_pc;
        end else begin
            case (state_q)
                frontend_pkg::FR_IDLE: begin
                    if (!mrq_busy_i) begin
                        state_q <= frontend_pkg::FR_ISSUE;
                        pc_q    <= {pc_line + 1'b1, {`LINE_SHIFT{1'b0}}};
                    end
                end
                frontend_pkg::FR_ISSUE: begin
                    state_q <= frontend_pkg::FR_RESP;
                end
                default: begin
                    state_q <= frontend_pkg::FR_IDLE;
                end
            endcase
        end
    end

    // Request tags follow the PC while idle and freeze once the read goes out
    always_ff @(posedge core_clock_i) begin
        if (state_q == frontend_pkg::FR_IDLE) begin
            req_pc_q    <= pc_q;
            req_fault_q <= pc_fault;
        end
    end

    // A line beyond the end of memory never reaches the memory at all
    assign rd_en_o   = (state_q == frontend_pkg::FR_ISSUE) && !req_fault_q;
    assign rd_addr_o = req_pc_q[`LINE_SHIFT +: ADDR_BITS];

    // The response dies here if a redirect lands in the same cycle
    assign mrq_vld_o = (state_q == frontend_pkg::FR_RESP) && !redirect_i;

    assign mrq_packet_o.instruction = req_fault_q ? 64'd0 : rd_data_i;
    assign mrq_packet_o.vpc         = req_pc_q;
    assign mrq_packet_o.excp_code   = req_fault_q ? frontend_pkg::EXC_INSTR_ACCESS_FAULT
                                                  : frontend_pkg::EXC_NONE;
    assign mrq_packet_o.excp_vld    = req_fault_q;

endmodule

/* logic/imem.sv */
// Instruction memory of 64-bit lines, read by the fetch requester and loaded through its write port
`timescale 1ns/10ps
`include "frontend_macros.svh"

module imem (
    input  wire logic                         core_clock_i,

    // Load port, used while the testbench fills the program
    input  wire logic                         we_i,
    input  wire logic [`IMEM_ADDR_BITS-1:0]   waddr_i,
    input  wire logic [63:0]                  wdata_i,

    input  wire logic                         rd_en_i,
    input  wire logic [`IMEM_ADDR_BITS-1:0]   rd_addr_i,
    output      logic [63:0]                  rd_data_o
);
    logic [63:0] mem_q [`IMEM_DEPTH_LINES];

    // Loads are honoured regardless of reset so the program can go in early
    always_ff @(posedge core_clock_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Registered read, data shows up one cycle after the enable
    always_ff @(posedge core_clock_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

/* logic/mrq.sv */
// Memory response queue between the fetch requester and predecode, built as a FIFO or a pass-through
`timescale 1ns/10ps
`include "frontend_macros.svh"

module mrq #(
    parameter int QUEUE_SZ  = `MRQ_QUEUE_SZ,
    parameter int QUEUE_OFF = `MRQ_QUEUE_OFF
) (
    input  wire logic                         core_clock_i,
    input  wire logic                         core_flush_i,
    input  wire logic                         reset_i,

    input  wire logic                         mrq_vld_i,
    input  wire frontend_pkg::fetch_packet_t  mrq_packet_i,
    output wire logic                         mrq_busy_o,

    output wire logic                         nx_stage_vld_o,
    output wire frontend_pkg::fetch_packet_t  nx_stage_packet_o,
    input  wire logic                         nx_stage_busy_i
);
    generate if (QUEUE_OFF != 0) begin : g_queue_off
        // Straight wires, so back-pressure comes from the next stage itself
        assign nx_stage_vld_o    = mrq_vld_i;
        assign nx_stage_packet_o = mrq_packet_i;
        assign mrq_busy_o        = nx_stage_busy_i;
    end else begin : g_queue
        localparam int PKT_BITS = $bits(frontend_pkg::fetch_packet_t);

        logic                queue_write;
        logic                queue_read;
        logic                queue_full;
        logic                queue_empty;
        logic [PKT_BITS-1:0] queue_rdata;

        // Writes are dropped when full, pops happen only when the next stage takes the head
        assign queue_write = mrq_vld_i && !queue_full;
        assign queue_read  = !nx_stage_busy_i && !queue_empty;

        assign mrq_busy_o        = queue_full;
        assign nx_stage_vld_o    = !queue_empty;
        assign nx_stage_packet_o = queue_rdata;

        sfifo2 #(
            .DEPTH (QUEUE_SZ),
            .WIDTH (PKT_BITS)
        ) u_response_queue (
            .core_clock_i (core_clock_i),
            .flush_i      (core_flush_i),
            .reset_i      (reset_i),
            .write_i      (queue_write),
            .wdata_i      (mrq_packet_i),
            .full_o       (queue_full),
            .read_i       (queue_read),
            .rdata_o      (queue_rdata),
            .empty_o      (queue_empty)
        );
    end endgenerate

endmodule

/* logic/sfifo2.sv */
// Flushable synchronous FIFO, instantiated by the memory response queue to hold fetch packets
`timescale 1ns/10ps

module sfifo2 #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32,
    localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire logic              core_clock_i,
    input  wire logic              flush_i,
    input  wire logic              reset_i,

    input  wire logic              write_i,
    input  wire logic [WIDTH-1:0]  wdata_i,
    output wire logic              full_o,

    input  wire logic              read_i,
    output wire logic [WIDTH-1:0]  rdata_o,
    output wire logic              empty_o
);
    // Storage flops, the head is read straight out of them
    logic [WIDTH-1:0] mem_q [DEPTH];

    // Pointers carry a wrap bit on top of the slot index
    logic [IDX_BITS:0] wr_ptr_q;
    logic [IDX_BITS:0] rd_ptr_q;
    logic              do_write;
    logic              do_read;

    // Step a pointer, wrapping at DEPTH so that any depth works, not only powers of two
    function automatic logic [IDX_BITS:0] ptr_inc(input logic [IDX_BITS:0] ptr);
        logic [IDX_BITS:0] nxt;
        if (ptr[IDX_BITS-1:0] == IDX_BITS'(DEPTH - 1)) begin
            nxt = {~ptr[IDX_BITS], {IDX_BITS{1'b0}}};
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Same slot on different laps means full, same slot on the same lap means empty
    assign full_o  = (wr_ptr_q[IDX_BITS-1:0] == rd_ptr_q[IDX_BITS-1:0]) &&
                     (wr_ptr_q[IDX_BITS] != rd_ptr_q[IDX_BITS]);
    assign empty_o = (wr_ptr_q == rd_ptr_q);

    // Requests against a full or empty FIFO are ignored here as well
    assign do_write = write_i && !full_o;
    assign do_read  = read_i && !empty_o;

    assign rdata_o = mem_q[rd_ptr_q[IDX_BITS-1:0]];

    always_ff @(posedge core_clock_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_read) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
        end
    end

    // A write landing with a flush is harmless since the pointers drop it
    always_ff @(posedge core_clock_i) begin
        if (do_write) begin
            mem_q[wr_ptr_q[IDX_BITS-1:0]] <= wdata_i;
        end
    end

endmodule

/* logic/frontend_pkg.sv */
// Shared frontend types, referenced by scoped name from the fetch and predecode modules
`include "frontend_macros.svh"

package frontend_pkg;

    // Exception reported alongside a fetched line
    typedef enum logic [3:0] {
        EXC_NONE               = 4'd0,
        EXC_INSTR_ACCESS_FAULT = 4'd1
    } excp_code_e;

    // Major opcodes that predecode cares about
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_OTHER,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LOAD,
        CLS_STORE
    } instr_class_e;

    // Fetch requester sequencing, one read in flight at most
    typedef enum logic [1:0] {
        FR_IDLE,
        FR_ISSUE,
        FR_RESP
    } fetch_state_e;

    // One 64-bit line as it leaves the fetch requester, low word first in program order
    typedef struct packed {
        logic [63:0]          instruction;
        logic [`PC_BITS-1:0]  vpc;
        excp_code_e           excp_code;
        logic                 excp_vld;
    } fetch_packet_t;

    typedef struct packed {
        logic [31:0]          instruction;
        logic [`PC_BITS-1:0]  vpc;
        instr_class_e         iclass;
        excp_code_e           excp_code;
        logic                 excp_vld;
    } predecoded_t;

endpackage

/* logic/frontend_macros.svh */
// Build-time switches for the fetch frontend, included by every design file that sizes from them
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Set to 1 when PCs may sit on 16-bit boundaries, 0 for 32-bit alignment only
`define ENABLE_C_EXTENSION 1

// Virtual PC width once the always-zero low bits are dropped
`define PC_BITS ((`ENABLE_C_EXTENSION == 1) ? 31 : 30)

// Position of the lowest line-index bit inside a PC
`define LINE_SHIFT ((`ENABLE_C_EXTENSION == 1) ? 2 : 1)

// Memory response queue depth, and 1 to build the queue as a plain pass-through
`define MRQ_QUEUE_SZ 8
`define MRQ_QUEUE_OFF 0

// Instruction memory size in 64-bit lines, and the width of a line index
`define IMEM_DEPTH_LINES 64
`define IMEM_ADDR_BITS $clog2(`IMEM_DEPTH_LINES)

// First PC fetched once reset is released
`define RESET_VPC 0

`endif
